//--- logic/ahb_in_pkg.sv
// AHB input stage shared definitions
// Bus widths, HTRANS/HBURST/HSIZE/HRESP encodings, address phase struct
`default_nettype none

package ahb_in_pkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  parameter int ADDR_W = 32;                // Default AHB address width

  typedef logic [ADDR_W-1:0] addr_t;        // HADDR
  typedef logic [2:0]        hsize_t;       // HSIZE
  typedef logic [3:0]        hprot_t;       // HPROT, passed along untouched
  typedef logic [3:0]        beat_off_t;    // Beat index within a wrap of up to 16

  // ------------------------------------------------
  // Encodings
  // ------------------------------------------------

  // Transfer type, bit 1 set means an active transfer
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Burst type, odd codes are incrementing
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,                        // Undefined length
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  // Transfer sizes handled by the wrap check
  localparam hsize_t SIZE_BYTE  = 3'b000;
  localparam hsize_t SIZE_HALF  = 3'b001;
  localparam hsize_t SIZE_WORD  = 3'b010;
  localparam hsize_t SIZE_DWORD = 3'b011;   // Widest supported size

  // Slave response
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01,
    RETRY = 2'b10,
    SPLIT = 2'b11
  } hresp_e;

  // ------------------------------------------------
  // Address phase
  // ------------------------------------------------
  // One complete address/control phase, 46 bits
  typedef struct packed {
    logic    sel;                           // HSEL for this port
    htrans_e trans;
    addr_t   addr;
    logic    write;                         // 1 for a write
    hsize_t  size;
    hburst_e burst;
    hprot_t  prot;
  } ahb_req_t;

endpackage

`default_nettype wire

//--- logic/ahb_in_hold.sv
// Input stage holding register and pending-transfer control
// Direct/held path mux and HREADYOUTS/HRESPS generation
`timescale 1ns/1ps
`default_nettype none

module ahb_in_hold #(
  parameter int ADDR_W = ahb_in_pkg::ADDR_W
) (
  input  wire                   HCLK,
  input  wire                   HRESETn,
  input  wire ahb_in_pkg::ahb_req_t s_req,      // Upstream address phase
  input  wire                   HREADYS,
  input  wire                   active_ip,      // Output stage owned by this port
  input  wire                   readyout_ip,
  input  wire ahb_in_pkg::hresp_e   resp_ip,
  output ahb_in_pkg::ahb_req_t  mux_req,        // Selected request to burst fix
  output ahb_in_pkg::htrans_e   src_trans,      // Master's own trans on selected path
  output logic                  load,
  output logic                  pend,
  output logic                  held_tran,      // Request to the arbiter
  output logic                  HREADYOUTS,
  output ahb_in_pkg::hresp_e    HRESPS
);

  import ahb_in_pkg::*;

  logic              addr_valid;   // Active transfer to this port
  logic              pend_next;
  logic              pend_q;
  logic              data_q;       // Data phase of an active transfer

  // Holding register fields
  htrans_e           hold_trans;
  logic [ADDR_W-1:0] hold_addr;
  logic              hold_write;
  hsize_t            hold_size;
  hburst_e           hold_burst;
  hprot_t            hold_prot;

  // ------------------------------------------------
  // Acceptance and holding register
  // ------------------------------------------------

  // NONSEQ or SEQ while selected
  assign addr_valid = s_req.sel & s_req.trans[1];
  assign load       = addr_valid & HREADYS;    // Accepted on this edge

  // Every accepted phase is captured, used only if the output stage is busy
  always_ff @(posedge HCLK)
  begin
    if (load)
    begin
      hold_trans <= s_req.trans;
      hold_addr  <= s_req.addr;
      hold_write <= s_req.write;
      hold_size  <= s_req.size;
      hold_burst <= s_req.burst;
      hold_prot  <= s_req.prot;
    end
  end

  // ------------------------------------------------
  // Pending flag and data phase
  // ------------------------------------------------

  // Set when accepted without the output stage, cleared when it completes
  always_comb
  begin
    if (load && !active_ip)
      pend_next = 1'b1;
    else if (active_ip && readyout_ip)
      pend_next = 1'b0;
    else
      pend_next = pend_q;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      pend_q <= 1'b0;
      data_q <= 1'b0;
    end
    else
    begin
      pend_q <= pend_next;
      if (HREADYS)
        data_q <= addr_valid;                  // Tracks address phase into data phase
    end
  end

  assign pend      = pend_q;
  assign held_tran = load | pend_q;            // Live in acceptance cycle and while held

  // ------------------------------------------------
  // Path select
  // ------------------------------------------------
  always_comb
  begin
    if (!pend_q)
    begin
      mux_req   = s_req;                       // Straight through
      src_trans = s_req.trans;
    end
    else
    begin
      // Held phase always starts a fresh transfer downstream
      mux_req.sel   = 1'b1;
      mux_req.trans = NONSEQ;
      mux_req.addr  = hold_addr;
      mux_req.write = hold_write;
      mux_req.size  = hold_size;
      mux_req.burst = hold_burst;
      mux_req.prot  = hold_prot;
      src_trans     = hold_trans;              // Original type, for burst override
    end
  end

  // ------------------------------------------------
  // Response to the master
  // ------------------------------------------------
  always_comb
  begin
    if (!data_q)
    begin
      HREADYOUTS = 1'b1;                       // Idle, busy or not selected
      HRESPS     = OKAY;
    end
    else if (pend_q)
    begin
      HREADYOUTS = 1'b0;                       // Stall until output stage takes it
      HRESPS     = OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

  // Any request raised to the arbiter is a selected transfer downstream
  a_held_sel : assert property (@(posedge HCLK) disable iff (!HRESETn)
    held_tran |-> mux_req.sel);

  // No wait state outside a registered data phase
  a_ready_idle : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !data_q |-> HREADYOUTS);

endmodule

`default_nettype wire

//--- logic/ahb_in_burst_fix.sv
// Early burst termination for the AHB input stage
// Burst override flag, wrap boundary check, trans/burst correction
`timescale 1ns/1ps
`default_nettype none

module ahb_in_burst_fix #(
  parameter int ADDR_W = ahb_in_pkg::ADDR_W
) (
  input  wire                       HCLK,
  input  wire                       HRESETn,
  input  wire ahb_in_pkg::ahb_req_t s_req,      // Direct upstream phase
  input  wire                       HREADYS,
  input  wire                       load,
  input  wire                       pend,
  input  wire                       active_ip,
  input  wire ahb_in_pkg::htrans_e  src_trans,
  input  wire ahb_in_pkg::ahb_req_t mux_req,
  output ahb_in_pkg::ahb_req_t      m_req       // Legal AHB to the output stage
);

  import ahb_in_pkg::*;

  logic [ADDR_W-1:0] src_addr;
  logic              override_next;
  logic              override_q;    // Burst interrupted, finish as INCR
  beat_off_t         beat_off;      // Address in units of transfer size
  beat_off_t         check_off;     // All ones on the last beat of a wrap
  logic              bound_en;
  logic              bound_q;       // Previous beat hit the wrap boundary

  assign src_addr = s_req.addr;

  // ------------------------------------------------
  // Burst override
  // ------------------------------------------------

  // A new burst or idle ends it, a held SEQ beat starts it
  always_comb
  begin
    if (s_req.trans == NONSEQ || s_req.trans == IDLE)
      override_next = 1'b0;
    else if (s_req.trans == SEQ && load && !active_ip)
      override_next = 1'b1;
    else
      override_next = override_q;
  end

  // ------------------------------------------------
  // Wrap boundary check
  // ------------------------------------------------
  always_comb
  begin
    case (s_req.size)
      SIZE_BYTE  : beat_off = src_addr[3:0];
      SIZE_HALF  : beat_off = src_addr[4:1];
      SIZE_WORD  : beat_off = src_addr[5:2];
      SIZE_DWORD : beat_off = src_addr[6:3];
      default    : beat_off = src_addr[3:0];  // Wider sizes unsupported
    endcase
  end

  // Pad unused upper bits with ones so only the wrap length counts
  always_comb
  begin
    case (s_req.burst)
      WRAP4   : check_off = {2'b11, beat_off[1:0]};
      WRAP8   : check_off = {1'b1, beat_off[2:0]};
      WRAP16  : check_off = beat_off;
      default : check_off = 4'h0;             // Incrementing bursts never wrap
    endcase
  end

  assign bound_en = s_req.trans[1] & HREADYS;  // Active beats only

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      override_q <= 1'b0;
      bound_q    <= 1'b0;
    end
    else
    begin
      if (HREADYS)
        override_q <= override_next;
      if (bound_en)
        bound_q <= (check_off == 4'hF);
    end
  end

  // ------------------------------------------------
  // Output correction
  // ------------------------------------------------
  always_comb
  begin
    m_req = mux_req;
    // SEQ -> NONSEQ, BUSY -> IDLE after the wrap point
    if (override_q && bound_q)
      m_req.trans = htrans_e'({mux_req.trans[1], 1'b0});
    if (override_q && src_trans != NONSEQ)
      m_req.burst = INCR;                      // Remaining beats of unknown count
  end

  // Interrupted burst never leaks its fixed length downstream
  a_incr_override : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (override_q && src_trans == SEQ) |-> (m_req.burst == INCR));

  // Override only starts together with a held transfer in the hold stage
  a_override_pend : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(override_q) |-> pend);

endmodule

`default_nettype wire

//--- logic/ahb_in_stage.sv
// AHB interconnect input stage top level
// Hold stage followed by early burst termination
`timescale 1ns/1ps
`default_nettype none

module ahb_in_stage #(
  parameter int ADDR_W = ahb_in_pkg::ADDR_W
) (
  input  wire                       HCLK,
  input  wire                       HRESETn,

  // Upstream master side
  input  wire ahb_in_pkg::ahb_req_t s_req,
  input  wire                       HREADYS,
  output wire                       HREADYOUTS,
  output ahb_in_pkg::hresp_e        HRESPS,

  // Output stage side
  output ahb_in_pkg::ahb_req_t      m_req,
  output wire                       held_tran,     // Arbiter request
  input  wire                       active_ip,
  input  wire                       readyout_ip,
  input  wire ahb_in_pkg::hresp_e   resp_ip
);

  import ahb_in_pkg::*;

  // ------------------------------------------------
  // Internal wires
  // ------------------------------------------------
  ahb_req_t mux_req;       // Direct or held phase
  htrans_e  src_trans;     // Master's trans for the selected phase
  logic     load;          // Address phase accepted
  logic     pend;          // Transfer waiting in holding register

  // Request struct is fixed at the package width
  if (ADDR_W != ahb_in_pkg::ADDR_W)
  begin : g_addr_w_check
    $error("ADDR_W must match the package address width");
  end

  // ------------------------------------------------
  // Hold stage
  // ------------------------------------------------
  ahb_in_hold #(
    .ADDR_W      (ADDR_W)
  ) u_hold (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .s_req       (s_req),
    .HREADYS     (HREADYS),
    .active_ip   (active_ip),
    .readyout_ip (readyout_ip),
    .resp_ip     (resp_ip),
    .mux_req     (mux_req),
    .src_trans   (src_trans),
    .load        (load),
    .pend        (pend),
    .held_tran   (held_tran),
    .HREADYOUTS  (HREADYOUTS),
    .HRESPS      (HRESPS)
  );

  // ------------------------------------------------
  // Burst termination
  // ------------------------------------------------
  ahb_in_burst_fix #(
    .ADDR_W      (ADDR_W)
  ) u_burst_fix (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .s_req       (s_req),
    .HREADYS     (HREADYS),
    .load        (load),
    .pend        (pend),
    .active_ip   (active_ip),
    .src_trans   (src_trans),
    .mux_req     (mux_req),
    .m_req       (m_req)
  );

endmodule

`default_nettype wire

//--- include/tb_ahb_in_tasks.svh
// Testbench helpers for the AHB input stage
// Bus cycle driving, bounded waits, value checks, LFSR address source
`ifndef TB_AHB_IN_TASKS_SVH
`define TB_AHB_IN_TASKS_SVH

localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
localparam int          WAIT_MAX  = 16;             // Cycles before a wait gives up

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < n; i++)
  begin
    val = {val[30:0], lfsr_state[0]};
    if (lfsr_state[0])
      lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
    else
      lfsr_state = lfsr_state >> 1;
  end
  return val;
endfunction

// Word transfer, write and prot picked from address bits
function automatic ahb_req_t make_req(input logic sel, input htrans_e trans,
                                      input addr_t addr, input hburst_e burst);
  ahb_req_t r;
  r.sel   = sel;
  r.trans = trans;
  r.addr  = addr;
  r.write = addr[2];
  r.size  = SIZE_WORD;
  r.burst = burst;
  r.prot  = addr[31:28];     // Passive field
  return r;
endfunction

// ------------------------------------------------
// Bus driving
// ------------------------------------------------

// Apply inputs, then let combinational paths settle
task automatic set_bus(input ahb_req_t req, input logic ready_in, input logic active,
                       input logic ready_ip, input hresp_e resp);
  s_req       = req;
  HREADYS     = ready_in;
  active_ip   = active;      // Output stage owned by this port
  readyout_ip = ready_ip;
  resp_ip     = resp;
  #1;
endtask

task automatic bus_cycle(input ahb_req_t req, input logic ready_in, input logic active,
                         input logic ready_ip, input hresp_e resp);
  @(negedge HCLK);
  set_bus(req, ready_in, active, ready_ip, resp);
endtask

// ------------------------------------------------
// Checks and waits
// ------------------------------------------------
task automatic check_val(input string name, input logic [63:0] got,
                         input logic [63:0] exp);
  check_count++;
  assert (got === exp)
  else
  begin
    error_count++;
    $display("[ERROR] %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
  end
endtask

task automatic report_timeout(input string what);
  error_count++;
  $display("Timeout after %0d cycles: %s", WAIT_MAX, what);
  finish_run();
endtask

// Inputs left alone, sampled on the falling edge before anything is driven
task automatic wait_ready();
  int cycles;
  cycles = 0;
  @(negedge HCLK);
  while (!HREADYOUTS && cycles < WAIT_MAX)
  begin
    @(negedge HCLK);
    cycles++;
  end
  if (!HREADYOUTS)
    report_timeout("HREADYOUTS never returned high");
endtask

task automatic wait_held_clear();
  int cycles;
  cycles = 0;
  @(negedge HCLK);
  while (held_tran && cycles < WAIT_MAX)
  begin
    @(negedge HCLK);
    cycles++;
  end
  if (held_tran)
    report_timeout("held_tran never dropped after the output stage took the transfer");
endtask

`endif

//--- tests/tb_ahb_in_stage.sv
// Directed testbench for the AHB input stage
// Clock, reset, DUT, five directed tests and the summary
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_in_stage;

  import ahb_in_pkg::*;

  logic        HCLK;
  logic        HRESETn;
  ahb_req_t    s_req;
  logic        HREADYS;
  logic        HREADYOUTS;
  hresp_e      HRESPS;
  ahb_req_t    m_req;
  logic        held_tran;
  logic        active_ip;
  logic        readyout_ip;
  hresp_e      resp_ip;
  logic [31:0] lfsr_state;
  int          error_count;
  int          check_count;

  `include "tb_ahb_in_tasks.svh"

  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;                   // 20 ns period
  end

  ahb_in_stage #(
    .ADDR_W      (ADDR_W)
  ) uut (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .s_req       (s_req),
    .HREADYS     (HREADYS),
    .HREADYOUTS  (HREADYOUTS),
    .HRESPS      (HRESPS),
    .m_req       (m_req),
    .held_tran   (held_tran),
    .active_ip   (active_ip),
    .readyout_ip (readyout_ip),
    .resp_ip     (resp_ip)
  );

  task automatic finish_run();
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  endtask

  // ------------------------------------------------
  // Directed tests
  // ------------------------------------------------
  task automatic reset_and_passthru();
    ahb_req_t req;
    bus_cycle('0, 1'b0, 1'b1, 1'b0, ERROR);     // Output stage response must be masked
    check_val("HREADYOUTS", HREADYOUTS, 1'b1);
    check_val("HRESPS", HRESPS, OKAY);
    check_val("held_tran", held_tran, 1'b0);
    repeat (3)
    begin
      req = make_req(1'b1, NONSEQ, rand_bits(32), SINGLE);
      bus_cycle(req, 1'b1, 1'b1, 1'b1, OKAY);
      check_val("m_req", m_req, req);           // Same cycle
    end
    bus_cycle('0, 1'b1, 1'b1, 1'b1, OKAY);
  endtask

  task automatic held_nonseq();
    ahb_req_t req;
    req = make_req(1'b1, NONSEQ, rand_bits(32), SINGLE);
    bus_cycle(req, 1'b1, 1'b0, 1'b1, OKAY);     // Other layer owns output stage
    check_val("held_tran", held_tran, 1'b1);
    bus_cycle('0, 1'b0, 1'b0, 1'b1, OKAY);
    check_val("m_req", m_req, req);             // Held copy, sel and NONSEQ
    check_val("HREADYOUTS", HREADYOUTS, 1'b0);
    check_val("HRESPS", HRESPS, OKAY);
    check_val("held_tran", held_tran, 1'b1);
    bus_cycle('0, 1'b0, 1'b1, 1'b0, OKAY);      // Granted, output stage stalls
    check_val("m_req", m_req, req);
    bus_cycle('0, 1'b0, 1'b1, 1'b1, OKAY);      // Completion edge
    wait_held_clear();
    set_bus('0, 1'b1, 1'b1, 1'b1, OKAY);
    check_val("HREADYOUTS", HREADYOUTS, 1'b1);
  endtask

  task automatic data_phase_resp();
    ahb_req_t req;
    req = make_req(1'b1, NONSEQ, rand_bits(32), SINGLE);
    bus_cycle(req, 1'b1, 1'b1, 1'b1, OKAY);
    bus_cycle('0, 1'b0, 1'b1, 1'b0, OKAY);      // Wait state
    check_val("HREADYOUTS", HREADYOUTS, 1'b0);
    bus_cycle('0, 1'b0, 1'b1, 1'b0, ERROR);     // Two-cycle error response
    check_val("HRESPS", HRESPS, ERROR);
    check_val("HREADYOUTS", HREADYOUTS, 1'b0);
    req.trans = IDLE;                           // Selected, no transfer
    bus_cycle(req, 1'b1, 1'b1, 1'b1, ERROR);
    check_val("HRESPS", HRESPS, ERROR);
    check_val("HREADYOUTS", HREADYOUTS, 1'b1);
    req.sel   = 1'b0;
    req.trans = NONSEQ;
    bus_cycle(req, 1'b1, 1'b1, 1'b0, ERROR);    // After IDLE, output stage ignored
    check_val("HREADYOUTS", HREADYOUTS, 1'b1);
    check_val("HRESPS", HRESPS, OKAY);
    bus_cycle('0, 1'b1, 1'b1, 1'b0, ERROR);     // After unselected transfer
    check_val("HREADYOUTS", HREADYOUTS, 1'b1);
    check_val("HRESPS", HRESPS, OKAY);
  endtask

  task automatic incr_override();
    addr_t    base;
    ahb_req_t beat;
    base = rand_bits(26) << 6;
    bus_cycle(make_req(1'b1, NONSEQ, base, INCR4), 1'b1, 1'b1, 1'b1, OKAY);
    bus_cycle(make_req(1'b1, SEQ, base + 4, INCR4), 1'b1, 1'b0, 1'b1, OKAY);
    beat = make_req(1'b1, SEQ, base + 8, INCR4);
    bus_cycle(beat, 1'b0, 1'b0, 1'b1, OKAY);    // SEQ beat held
    check_val("HREADYOUTS", HREADYOUTS, 1'b0);
    check_val("m_req.addr", m_req.addr, base + 4);
    check_val("m_req.trans", m_req.trans, NONSEQ);
    check_val("m_req.burst", m_req.burst, INCR);
    bus_cycle(beat, 1'b0, 1'b1, 1'b1, OKAY);
    wait_ready();
    set_bus(beat, 1'b1, 1'b1, 1'b1, OKAY);
    check_val("m_req.trans", m_req.trans, SEQ);
    check_val("m_req.burst", m_req.burst, INCR);
    bus_cycle(make_req(1'b1, SEQ, base + 12, INCR4), 1'b1, 1'b1, 1'b1, OKAY);
    check_val("m_req.burst", m_req.burst, INCR);
    bus_cycle(make_req(1'b1, NONSEQ, base + 32, INCR4), 1'b1, 1'b1, 1'b1, OKAY);
    check_val("m_req.burst", m_req.burst, INCR4);
    bus_cycle(make_req(1'b1, SEQ, base + 36, INCR4), 1'b1, 1'b1, 1'b1, OKAY);
    check_val("m_req.burst", m_req.burst, INCR4);  // Master's burst back
    bus_cycle('0, 1'b1, 1'b1, 1'b1, OKAY);
  endtask

  // Four-word wrap starting at offset 0x4, boundary after offset 0xC
  task automatic wrap_boundary();
    addr_t    wrap;
    ahb_req_t beat;
    wrap = rand_bits(28) << 4;
    bus_cycle(make_req(1'b1, NONSEQ, wrap + 4, WRAP4), 1'b1, 1'b1, 1'b1, OKAY);
    bus_cycle(make_req(1'b1, SEQ, wrap + 8, WRAP4), 1'b1, 1'b0, 1'b1, OKAY);
    beat = make_req(1'b1, SEQ, wrap + 12, WRAP4);
    bus_cycle(beat, 1'b0, 1'b0, 1'b1, OKAY);
    check_val("m_req.burst", m_req.burst, INCR);
    bus_cycle(beat, 1'b0, 1'b1, 1'b1, OKAY);
    wait_ready();
    set_bus(beat, 1'b1, 1'b1, 1'b1, OKAY);
    check_val("m_req.trans", m_req.trans, SEQ);
    bus_cycle(make_req(1'b1, BUSY, wrap, WRAP4), 1'b1, 1'b1, 1'b1, OKAY);
    check_val("m_req.trans", m_req.trans, IDLE);
    bus_cycle(make_req(1'b1, SEQ, wrap, WRAP4), 1'b1, 1'b1, 1'b1, OKAY);
    check_val("m_req.trans", m_req.trans, NONSEQ);
    check_val("m_req.burst", m_req.burst, INCR);
    bus_cycle('0, 1'b1, 1'b1, 1'b1, OKAY);
  endtask

  // ------------------------------------------------
  // Sequence
  // ------------------------------------------------
  initial
  begin
    lfsr_state  = 32'd86454;
    error_count = 0;
    check_count = 0;
    HRESETn     = 1'b0;
    set_bus('0, 1'b0, 1'b1, 1'b0, ERROR);       // Bus held off through reset
    repeat (4) @(negedge HCLK);                 // Four rising edges in reset
    HRESETn = 1'b1;
    reset_and_passthru();
    held_nonseq();
    data_phase_resp();
    incr_override();
    wrap_boundary();
    finish_run();
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
logic/ahb_in_pkg.sv
logic/ahb_in_hold.sv
logic/ahb_in_burst_fix.sv
logic/ahb_in_stage.sv
tests/tb_ahb_in_stage.sv
